/* design/simd_mul_pkg.sv */
// Shared definitions for the packed-SIMD signed multiplier
// Operation and kernel-mode encodings, width constants, operand word view

`default_nettype none

package simd_mul_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and saturation values
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN    = 32;
  localparam int unsigned BYTE_W  = 8;
  localparam int unsigned HALF_W  = 16;
  localparam int unsigned NUM_KER = 8;
  // 9x9 signed kernel product
  localparam int unsigned PP_W    = 18;

  localparam logic [BYTE_W-1:0] Q7_MAX  = 8'h7f;
  localparam logic [HALF_W-1:0] Q15_MAX = 16'h7fff;
  localparam logic [XLEN-1:0]   W32_MAX = 32'h7fff_ffff;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_KHM8   = 4'd0,
    OP_KHMX8  = 4'd1,
    OP_KHM16  = 4'd2,
    OP_KHMX16 = 4'd3,
    OP_SMBB16 = 4'd4,
    OP_SMBT16 = 4'd5,
    OP_SMTT16 = 4'd6,
    OP_KMDA   = 4'd7,
    OP_SMDS   = 4'd8,
    OP_SMMWB  = 4'd9,
    OP_SMMWT  = 4'd10
  } simd_op_e;

  // Grouping of the eight byte kernels
  typedef enum logic [1:0] {
    M8X8   = 2'd0,
    M16X16 = 2'd1,
    M32X16 = 2'd2
  } mul_mode_e;

  // One operand word, seen as bytes or as halfwords
  typedef union packed {
    logic [XLEN/BYTE_W-1:0][BYTE_W-1:0] b;
    logic [XLEN/HALF_W-1:0][HALF_W-1:0] h;
  } simd_word_u;

endpackage

`default_nettype wire

/* design/simd_mul_operand_mux.sv */
// Operation decoder and operand router
// Picks the kernel mode and the b halfword of each kernel group,
// then hands byte pairs and Baugh-Wooley sign bits to the kernels

`default_nettype none

module simd_mul_operand_mux (
  input  simd_mul_pkg::simd_op_e                                   op_i,
  input  simd_mul_pkg::simd_word_u                                 op_a_i,
  input  simd_mul_pkg::simd_word_u                                 op_b_i,
  output logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::BYTE_W-1:0] ker_a_o,
  output logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::BYTE_W-1:0] ker_b_o,
  output logic [simd_mul_pkg::NUM_KER-1:0]                          sign_a_o,
  output logic [simd_mul_pkg::NUM_KER-1:0]                          sign_b_o,
  output simd_mul_pkg::mul_mode_e                                   mode_o,
  output logic                                                      crossed_o
);

  import simd_mul_pkg::*;

  // Bit 0 set: group 0 takes b.h1; bit 1 set: group 1 takes b.h0
  logic [1:0] quadrant;
  logic [1:0][1:0][BYTE_W-1:0] b_grp;

  ////////////////////////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    mode_o    = M16X16;
    quadrant  = 2'b00;
    crossed_o = 1'b0;
    unique case (op_i)
      OP_KHM8:   mode_o = M8X8;
      OP_KHMX8: begin
        mode_o    = M8X8;
        crossed_o = 1'b1;
      end
      OP_KHMX16: begin
        quadrant  = 2'b11;
        crossed_o = 1'b1;
      end
      // Both groups see the top halfword of b
      OP_SMBT16, OP_SMTT16: quadrant = 2'b01;
      OP_SMMWB: begin
        mode_o   = M32X16;
        quadrant = 2'b10;
      end
      OP_SMMWT: begin
        mode_o   = M32X16;
        quadrant = 2'b01;
      end
      default: begin
        mode_o   = M16X16;
        quadrant = 2'b00;
      end
    endcase
  end

  // Halfword of b seen by each kernel group
  assign b_grp[0] = op_b_i.h[quadrant[0]];
  assign b_grp[1] = op_b_i.h[~quadrant[1]];

  ////////////////////////////////////////////////////////////
  // Kernel routing and sign bits
  ////////////////////////////////////////////////////////////

  // Kernel index is {group, a byte, b byte}
  always_comb begin : route
    int k;
    logic msb_a;
    logic msb_b;
    for (int g = 0; g < 2; g++) begin
      for (int ia = 0; ia < 2; ia++) begin
        for (int ib = 0; ib < 2; ib++) begin
          k = 4 * g + 2 * ia + ib;
          ker_a_o[k] = op_a_i.b[2 * g + ia];
          ker_b_o[k] = b_grp[g][ib];
          msb_a = op_a_i.b[2 * g + ia][BYTE_W-1];
          msb_b = b_grp[g][ib][BYTE_W-1];
          case (mode_o)
            M8X8: begin
              sign_a_o[k] = msb_a;
              sign_b_o[k] = msb_b;
            end
            M16X16: begin
              sign_a_o[k] = (ia == 1) && msb_a;
              sign_b_o[k] = (ib == 1) && msb_b;
            end
            default: begin
              // Only the top byte of the full a word carries sign
              sign_a_o[k] = (g == 1) && (ia == 1) && msb_a;
              sign_b_o[k] = (ib == 1) && msb_b;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/simd_mul_kernel_array.sv */
// Array of eight signed 9x9 Baugh-Wooley byte kernels
// Each factor is a byte extended by its routed sign bit

`default_nettype none

module simd_mul_kernel_array (
  input  logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::BYTE_W-1:0] ker_a_i,
  input  logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::BYTE_W-1:0] ker_b_i,
  input  logic [simd_mul_pkg::NUM_KER-1:0]                          sign_a_i,
  input  logic [simd_mul_pkg::NUM_KER-1:0]                          sign_b_i,
  output logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::PP_W-1:0]   pp_o
);

  import simd_mul_pkg::*;

  ////////////////////////////////////////////////////////////
  // Byte kernels
  ////////////////////////////////////////////////////////////

  logic signed [BYTE_W:0] fac_a [NUM_KER];
  logic signed [BYTE_W:0] fac_b [NUM_KER];

  for (genvar k = 0; k < NUM_KER; k++) begin : g_ker
    // Sign bit clear means the byte counts as unsigned
    assign fac_a[k] = {sign_a_i[k], ker_a_i[k]};
    assign fac_b[k] = {sign_b_i[k], ker_b_i[k]};

    // 9x9 signed product fills the 18-bit partial product
    assign pp_o[k] = fac_a[k] * fac_b[k];
  end

endmodule

`default_nettype wire

/* design/simd_mul_kernel_adders.sv */
// Kernel adder tree
// First level builds one signed 16x16 product per kernel group
// Second level forms the 32x16 product or the dual-product sum or difference

`default_nettype none

module simd_mul_kernel_adders (
  input  logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::PP_W-1:0] pp_i,
  input  simd_mul_pkg::mul_mode_e                                 mode_i,
  input  simd_mul_pkg::simd_op_e                                  op_i,
  output logic [1:0][simd_mul_pkg::XLEN-1:0]                      half_sum_o,
  output logic [simd_mul_pkg::XLEN+simd_mul_pkg::HALF_W-1:0]      word_sum_o
);

  import simd_mul_pkg::*;

  localparam int unsigned WIDE_W = XLEN + HALF_W;

  logic [1:0][XLEN-1:0] part_lo;
  logic [1:0][XLEN-1:0] part_hi;
  logic [1:0][XLEN-1:0] grp_prod;

  logic [WIDE_W-1:0] add_x;
  logic [WIDE_W-1:0] add_y;
  logic              sub;

  function automatic logic [XLEN-1:0] sext_pp(input logic [PP_W-1:0] pp);
    return {{(XLEN-PP_W){pp[PP_W-1]}}, pp};
  endfunction

  function automatic logic [WIDE_W-1:0] sext_wide(input logic [XLEN-1:0] val);
    return {{HALF_W{val[XLEN-1]}}, val};
  endfunction

  ////////////////////////////////////////////////////////////
  // 16x16 group products
  ////////////////////////////////////////////////////////////

  // Kernels 4g+1 and 4g+2 carry the cross terms at weight 2^8
  always_comb begin
    for (int g = 0; g < 2; g++) begin
      part_lo[g]  = sext_pp(pp_i[4*g]) + (sext_pp(pp_i[4*g+1]) << BYTE_W);
      part_hi[g]  = sext_pp(pp_i[4*g+2]) + (sext_pp(pp_i[4*g+3]) << BYTE_W);
      grp_prod[g] = part_lo[g] + (part_hi[g] << BYTE_W);
    end
  end

  assign half_sum_o = grp_prod;

  ////////////////////////////////////////////////////////////
  // 32x16 alignment or dual-product add
  ////////////////////////////////////////////////////////////

  assign sub = (op_i == OP_SMDS);

  always_comb begin
    if (mode_i == M32X16) begin
      // High group holds a.h1 * b, one halfword up
      add_x = {grp_prod[1], {HALF_W{1'b0}}};
      add_y = sext_wide(grp_prod[0]);
    end else begin
      add_x = sext_wide(grp_prod[1]);
      // Inverted low product plus carry-in gives the difference
      add_y = sext_wide(grp_prod[0]) ^ {WIDE_W{sub}};
    end
  end

  assign word_sum_o = add_x + add_y + {{(WIDE_W-1){1'b0}}, sub};

endmodule

`default_nettype wire

/* design/simd_mul_result_stage.sv */
// Result stage
// Saturation detection, lane/word result select, output register

`default_nettype none

module simd_mul_result_stage (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    start_i,
  input  simd_mul_pkg::simd_op_e                                  op_i,
  input  simd_mul_pkg::simd_word_u                                op_a_i,
  input  simd_mul_pkg::simd_word_u                                op_b_i,
  input  logic                                                    crossed_i,
  input  logic [simd_mul_pkg::NUM_KER-1:0][simd_mul_pkg::PP_W-1:0] pp_i,
  input  logic [1:0][simd_mul_pkg::XLEN-1:0]                      half_sum_i,
  input  logic [simd_mul_pkg::XLEN+simd_mul_pkg::HALF_W-1:0]      word_sum_i,
  output logic [simd_mul_pkg::XLEN-1:0]                           result_o,
  output logic                                                    valid_o,
  output logic                                                    ov_o
);

  import simd_mul_pkg::*;

  logic [3:0]      sat_q7;
  logic [1:0]      sat_q15;
  logic            sat_w;
  logic [XLEN-1:0] lane_q7;
  logic [XLEN-1:0] lane_q15;
  logic [XLEN-1:0] result_d;
  logic            ov_d;

  logic [XLEN-1:0] result_q;
  logic            valid_q;
  logic            ov_q;

  ////////////////////////////////////////////////////////////
  // Lane results and saturation
  ////////////////////////////////////////////////////////////

  // Q7 lanes: straight uses kernels 4g and 4g+3, crossed uses 4g+1 and 4g+2
  always_comb begin : q7_lanes
    int k;
    for (int i = 0; i < 4; i++) begin
      k = crossed_i ? 4 * (i / 2) + 1 + (i % 2) : 4 * (i / 2) + 3 * (i % 2);
      // -128 times -128 is the only product that overflows Q7
      sat_q7[i] = (op_a_i.b[i] == ~Q7_MAX) &&
                  (op_b_i.b[i ^ int'(crossed_i)] == ~Q7_MAX);
      lane_q7[i*BYTE_W +: BYTE_W] = sat_q7[i] ? Q7_MAX
                                              : pp_i[k][2*BYTE_W-2 -: BYTE_W];
    end
  end

  always_comb begin
    for (int g = 0; g < 2; g++) begin
      sat_q15[g] = (op_a_i.h[g] == ~Q15_MAX) &&
                   (op_b_i.h[g ^ int'(crossed_i)] == ~Q15_MAX);
      lane_q15[g*HALF_W +: HALF_W] = sat_q15[g] ? Q15_MAX
                                                : half_sum_i[g][2*HALF_W-2 -: HALF_W];
    end
  end

  // Two products of 2^30 push the KMDA sum past the word range
  assign sat_w = (half_sum_i[0] == 32'h4000_0000) &&
                 (half_sum_i[1] == 32'h4000_0000);

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_d = '0;
    ov_d     = 1'b0;
    unique case (op_i)
      OP_KHM8, OP_KHMX8: begin
        result_d = lane_q7;
        ov_d     = |sat_q7;
      end
      OP_KHM16, OP_KHMX16: begin
        result_d = lane_q15;
        ov_d     = |sat_q15;
      end
      OP_SMBB16, OP_SMBT16: result_d = half_sum_i[0];
      OP_SMTT16:            result_d = half_sum_i[1];
      OP_KMDA: begin
        result_d = sat_w ? W32_MAX : word_sum_i[XLEN-1:0];
        ov_d     = sat_w;
      end
      OP_SMDS:              result_d = word_sum_i[XLEN-1:0];
      // Upper word of the 48-bit product
      OP_SMMWB, OP_SMMWT:   result_d = word_sum_i[XLEN+HALF_W-1:HALF_W];
      default: begin
        result_d = '0;
        ov_d     = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      ov_q     <= 1'b0;
      result_q <= '0;
    end else begin
      valid_q <= start_i;
      // Hold the last result between operations
      if (start_i) begin
        result_q <= result_d;
        ov_q     <= ov_d;
      end
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;
  assign ov_o     = ov_q;

endmodule

`default_nettype wire

/* design/simd_mul_top.sv */
// Top level of the packed-SIMD signed multiplier
// Operand mux, kernel array, kernel adders and result stage

`default_nettype none

module simd_mul_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  input  simd_mul_pkg::simd_op_e         op_i,
  input  logic [simd_mul_pkg::XLEN-1:0]  op_a_i,
  input  logic [simd_mul_pkg::XLEN-1:0]  op_b_i,
  output logic [simd_mul_pkg::XLEN-1:0]  result_o,
  output logic                           valid_o,
  output logic                           ov_o
);

  import simd_mul_pkg::*;

  logic [NUM_KER-1:0][BYTE_W-1:0] ker_a;
  logic [NUM_KER-1:0][BYTE_W-1:0] ker_b;
  logic [NUM_KER-1:0]             sign_a;
  logic [NUM_KER-1:0]             sign_b;
  mul_mode_e                      mode;
  logic                           crossed;
  logic [NUM_KER-1:0][PP_W-1:0]   pp;
  logic [1:0][XLEN-1:0]           half_sum;
  logic [XLEN+HALF_W-1:0]         word_sum;

  simd_mul_operand_mux i_operand_mux (
    .op_i      (op_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .ker_a_o   (ker_a),
    .ker_b_o   (ker_b),
    .sign_a_o  (sign_a),
    .sign_b_o  (sign_b),
    .mode_o    (mode),
    .crossed_o (crossed)
  );

  simd_mul_kernel_array i_kernel_array (
    .ker_a_i  (ker_a),
    .ker_b_i  (ker_b),
    .sign_a_i (sign_a),
    .sign_b_i (sign_b),
    .pp_o     (pp)
  );

  simd_mul_kernel_adders i_kernel_adders (
    .pp_i       (pp),
    .mode_i     (mode),
    .op_i       (op_i),
    .half_sum_o (half_sum),
    .word_sum_o (word_sum)
  );

  simd_mul_result_stage i_result_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .op_i       (op_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .crossed_i  (crossed),
    .pp_i       (pp),
    .half_sum_i (half_sum),
    .word_sum_i (word_sum),
    .result_o   (result_o),
    .valid_o    (valid_o),
    .ov_o       (ov_o)
  );

endmodule

`default_nettype wire

/* test/tb_simd_mul.sv */
// Testbench for the packed-SIMD signed multiplier
// Random and corner operands checked against a reference model
// One-cycle result latency and a cycle-count watchdog

`default_nettype none

module tb_simd_mul;

  timeunit 1ns;
  timeprecision 1ps;

  import simd_mul_pkg::*;

  localparam int unsigned SEED         = 31;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned IDLE_CYCLES  = 10;
  localparam int unsigned N_RAND_OP    = 30;
  localparam int unsigned N_CORNER     = 6;
  localparam int unsigned N_SAT_OPS    = 5;
  localparam int unsigned N_B2B        = 200;
  localparam int unsigned N_GAP        = 150;
  // Sum of all test lengths, one flush cycle per test, plus margin
  localparam int unsigned MAX_CYCLES   = RESET_CYCLES + IDLE_CYCLES + 11 * N_RAND_OP +
                                         N_SAT_OPS * N_CORNER * N_CORNER + N_B2B +
                                         N_GAP + 5 + 100;

  logic            clk_i;
  logic            rst_ni;
  logic            start_i;
  simd_op_e        op_i;
  logic [XLEN-1:0] op_a_i;
  logic [XLEN-1:0] op_b_i;
  logic [XLEN-1:0] result_o;
  logic            valid_o;
  logic            ov_o;

  logic [XLEN-1:0] exp_res_q [$];
  logic            exp_ov_q [$];
  simd_op_e        exp_op_q [$];
  logic            prev_start;
  logic [XLEN-1:0] held_res;
  logic            held_ov;
  int unsigned     n_checks;
  int unsigned     n_errors;
  int unsigned     test_checks0;
  int unsigned     test_errors0;
  int unsigned     cycle_cnt;

  logic [XLEN-1:0] corners [N_CORNER] = '{
    32'h8080_8080, 32'h8000_8000, 32'h0000_0000,
    32'hffff_ffff, 32'h7f80_807f, 32'h8000_0001
  };
  simd_op_e sat_ops [N_SAT_OPS] = '{OP_KHM8, OP_KHMX8, OP_KHM16, OP_KHMX16, OP_KMDA};

  simd_mul_top i_simd_mul_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .ov_o     (ov_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic void model_op(input simd_op_e op, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b,
                                   output logic [XLEN-1:0] res, output logic ov);
    simd_word_u         wa;
    simd_word_u         wb;
    int                 sel;
    logic signed [31:0] p;
    logic signed [31:0] p_hi;
    logic signed [31:0] p_lo;
    longint             sum;
    wa  = a;
    wb  = b;
    res = '0;
    ov  = 1'b0;
    p_hi = $signed(wa.h[1]) * $signed(wb.h[1]);
    p_lo = $signed(wa.h[0]) * $signed(wb.h[0]);
    case (op)
      OP_KHM8, OP_KHMX8: begin
        for (int i = 0; i < 4; i++) begin
          sel = (op == OP_KHMX8) ? (i ^ 1) : i;
          if (wa.b[i] == 8'h80 && wb.b[sel] == 8'h80) begin
            res[8*i +: 8] = 8'h7f;
            ov = 1'b1;
          end else begin
            p = $signed(wa.b[i]) * $signed(wb.b[sel]);
            res[8*i +: 8] = p[14:7];
          end
        end
      end
      OP_KHM16, OP_KHMX16: begin
        for (int g = 0; g < 2; g++) begin
          sel = (op == OP_KHMX16) ? (g ^ 1) : g;
          if (wa.h[g] == 16'h8000 && wb.h[sel] == 16'h8000) begin
            res[16*g +: 16] = 16'h7fff;
            ov = 1'b1;
          end else begin
            p = $signed(wa.h[g]) * $signed(wb.h[sel]);
            res[16*g +: 16] = p[30:15];
          end
        end
      end
      OP_SMBB16: res = p_lo;
      OP_SMBT16: begin
        p = $signed(wa.h[0]) * $signed(wb.h[1]);
        res = p;
      end
      OP_SMTT16: res = p_hi;
      OP_KMDA: begin
        sum = longint'(p_hi) + longint'(p_lo);
        if (sum > 64'sd2147483647) begin
          res = 32'h7fff_ffff;
          ov  = 1'b1;
        end else begin
          res = sum[31:0];
        end
      end
      OP_SMDS: res = p_hi - p_lo;
      default: begin
        // SMMWB and SMMWT keep the upper word of the 48-bit product
        sel = (op == OP_SMMWT) ? 1 : 0;
        sum = longint'($signed(a)) * longint'($signed(wb.h[sel]));
        res = sum[47:16];
      end
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking and driving
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs registered in the previous cycle, read at the falling edge
  task automatic check_outputs();
    simd_op_e        op;
    logic [XLEN-1:0] res;
    logic            ov;
    if (prev_start) begin
      check_eq(32'(valid_o), 32'd1, "valid_o one cycle after start");
      if (exp_res_q.size() == 0) begin
        n_errors++;
        $display("Result was due but no expected value was queued");
      end else begin
        op  = exp_op_q.pop_front();
        res = exp_res_q.pop_front();
        ov  = exp_ov_q.pop_front();
        check_eq(result_o, res, $sformatf("result_o for %s", op.name()));
        check_eq(32'(ov_o), 32'(ov), $sformatf("ov_o for %s", op.name()));
        held_res = res;
        held_ov  = ov;
      end
    end else begin
      check_eq(32'(valid_o), 32'd0, "valid_o after a cycle without start");
      check_eq(result_o, held_res, "result_o held while idle");
      check_eq(32'(ov_o), 32'(held_ov), "ov_o held while idle");
    end
  endtask

  task automatic run_cycle(input logic st, input simd_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp_res;
    logic            exp_ov;
    @(negedge clk_i);
    check_outputs();
    start_i = st;
    op_i    = op;
    op_a_i  = a;
    op_b_i  = b;
    if (st) begin
      model_op(op, a, b, exp_res, exp_ov);
      exp_res_q.push_back(exp_res);
      exp_ov_q.push_back(exp_ov);
      exp_op_q.push_back(op);
    end
    prev_start = st;
  endtask

  function automatic simd_op_e rand_op();
    return simd_op_e'($urandom_range(10, 0));
  endfunction

  // Idle cycle that also checks the last pending result
  task automatic report_test(input string name);
    run_cycle(1'b0, rand_op(), $urandom, $urandom);
    $display("%s: %0d checks, %0d errors", name, n_checks - test_checks0,
             n_errors - test_errors0);
    test_checks0 = n_checks;
    test_errors0 = n_errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned seed_dummy;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    op_i         = OP_KHM8;
    op_a_i       = '0;
    op_b_i       = '0;
    prev_start   = 1'b0;
    held_res     = '0;
    held_ov      = 1'b0;
    n_checks     = 0;
    n_errors     = 0;
    test_checks0 = 0;
    test_errors0 = 0;
    seed_dummy   = $urandom(SEED);

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state then idle cycles with changing inputs
    check_eq(32'(valid_o), 32'd0, "valid_o after reset");
    check_eq(32'(ov_o), 32'd0, "ov_o after reset");
    check_eq(result_o, 32'd0, "result_o after reset");
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      run_cycle(1'b0, rand_op(), $urandom, $urandom);
    end
    report_test("reset_idle");

    for (int op = 0; op <= 10; op++) begin
      for (int i = 0; i < N_RAND_OP; i++) begin
        run_cycle(1'b1, simd_op_e'(op), $urandom, $urandom);
      end
    end
    report_test("random_all_ops");

    foreach (sat_ops[s]) begin
      foreach (corners[ia]) begin
        foreach (corners[ib]) begin
          run_cycle(1'b1, sat_ops[s], corners[ia], corners[ib]);
        end
      end
    end
    report_test("saturation_corners");

    for (int i = 0; i < N_B2B; i++) begin
      run_cycle(1'b1, rand_op(), $urandom, $urandom);
    end
    report_test("back_to_back");

    for (int i = 0; i < N_GAP; i++) begin
      run_cycle(1'($urandom_range(1, 0)), rand_op(), $urandom, $urandom);
    end
    report_test("random_gaps");

    $display("Summary: %0d checks passed, %0d failed", n_checks - n_errors, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/simd_mul_pkg.sv
design/simd_mul_operand_mux.sv
design/simd_mul_kernel_array.sv
design/simd_mul_kernel_adders.sv
design/simd_mul_result_stage.sv
design/simd_mul_top.sv
test/tb_simd_mul.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_simd_mul \
  -Mdir obj_dir -o sim_tb || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/sim_tb) || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "All tests passed!" && exit 0 || exit 1
